// ==== nn_layer.f ====
verilog/nn_pkg.sv
verilog/input_sequencer.sv
verilog/weight_rom.sv
verilog/feed_forward_node.sv
verilog/feed_forward_hidden_layer.sv
verilog/nn_top.sv
tests/nn_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module nn_tb -f nn_layer.f -o nn_sim
	out="$$(./obj_dir/nn_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

// ==== weights.hex ====
// one row per neuron: the weights for inputs 0 to 3, then the bias
// every value is signed Q4.12 in hex, so 1000 is 1.0 and f000 is -1.0
1000 0800 f800 0400 0100
f000 1000 0c00 f400 0000
0200 fe00 0300 fd00 ff00
2000 2000 2000 2000 0800
e000 e000 1000 f000 f800
0666 f99a 0333 0ccd 0200
7fff 8000 4000 c000 0000
0100 0100 0100 0100 7000

// ==== tests/nn_tb.sv ====
`timescale 1ns/1ps
module nn_tb import nn_pkg::*; ();

	localparam int RESET_CYCLES = 10;
	localparam int NUM_FIXED = 7;
	localparam int NUM_RANDOM = 20;
	localparam int NUM_TESTS = NUM_FIXED + NUM_RANDOM;
	localparam int LATENCY = NUM_INPUTS + 3; // i_valid edge to the o_valid edge
	localparam int SAT_HIGH_ENTRY = 3;
	localparam int SAT_LOW_ENTRY = 4;
	localparam int SAT_NEURON = 3; // its weights are all 2.0, so full scale inputs overflow

	// each entry needs NUM_INPUTS writes plus about ten cycles of start, run and checks
	localparam int MAX_CYCLES = RESET_CYCLES + 4 + NUM_TESTS * (NUM_INPUTS + 14);

	logic                             clk = 1'b0;
	logic                             rst_n;
	logic                             i_in_we;
	logic [IN_ADDR_WIDTH-1:0]         i_in_addr;
	logic [DATA_WIDTH-1:0]            i_in_data;
	act_op_t                          i_act_mode;
	logic                             i_valid;
	logic                             o_busy;
	logic                             o_valid;
	logic [NUM_HIDDEN*DATA_WIDTH-1:0] o_hidden;

	// input 0 sits in the low bits of each stimulus vector
	logic [NUM_INPUTS*DATA_WIDTH-1:0] tab_x [NUM_TESTS];
	act_op_t                          tab_mode [NUM_TESTS];
	logic                             tab_poke [NUM_TESTS]; // start and write again while busy

	logic [DATA_WIDTH-1:0] rom [ROM_DEPTH];
	int                    seed;
	int                    errors = 0;
	int                    checks = 0;
	int                    cycle_count = 0;

	nn_top DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_in_we    (i_in_we),
		.i_in_addr  (i_in_addr),
		.i_in_data  (i_in_data),
		.i_act_mode (i_act_mode),
		.i_valid    (i_valid),
		.o_busy     (o_busy),
		.o_valid    (o_valid),
		.o_hidden   (o_hidden)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the layer never finished its run", cycle_count);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic check_hidden(input int idx, input logic [DATA_WIDTH-1:0] got,
			input logic [DATA_WIDTH-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: o_hidden[%0d] is %h, expected %h", idx, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s is %h, expected %h", name, got, exp);
		end
	endtask

	// Q4.12 neuron built from scaled products, then bias, then optional leaky slope and clamp
	function automatic logic [DATA_WIDTH-1:0] expected_neuron(input int n,
			input logic [NUM_INPUTS*DATA_WIDTH-1:0] xv, input act_op_t mode);
		longint sum;
		longint x;
		longint w;
		sum = 0;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			x = longint'($signed(xv[i*DATA_WIDTH +: DATA_WIDTH]));
			w = longint'($signed(rom[n*ROW_WORDS + i]));
			sum = sum + ((x * w) >>> FRAC_BITS); // each product is rescaled before summing
		end
		sum = sum + longint'($signed(rom[n*ROW_WORDS + NUM_INPUTS]));
		if (mode == ACT_LEAKY_RELU && sum < 0) begin
			sum = (sum * longint'(ALPHA_Q)) >>> FRAC_BITS;
		end
		if (sum > 32767) begin
			return 16'h7fff;
		end else if (sum < -32768) begin
			return 16'h8000;
		end
		return sum[DATA_WIDTH-1:0];
	endfunction

	task automatic add_entry(input int e, input logic [NUM_INPUTS*DATA_WIDTH-1:0] xv,
			input act_op_t mode, input logic poke);
		tab_x[e]    = xv;
		tab_mode[e] = mode;
		tab_poke[e] = poke;
	endtask

	task automatic build_table();
		logic [NUM_INPUTS*DATA_WIDTH-1:0] xv;
		logic [DATA_WIDTH-1:0]            v;
		int                               r;
		add_entry(0, {16'h0200, 16'hfc00, 16'h0800, 16'h0400}, ACT_LINEAR, 1'b0);
		add_entry(1, {16'hf800, 16'h1000, 16'h0800, 16'hf000}, ACT_LEAKY_RELU, 1'b0);
		add_entry(2, {16'h0100, 16'h0400, 16'hf400, 16'h0c00}, ACT_LEAKY_RELU, 1'b0);
		add_entry(3, {16'h7fff, 16'h7fff, 16'h7fff, 16'h7fff}, ACT_LINEAR, 1'b0);
		add_entry(4, {16'h8000, 16'h8000, 16'h8000, 16'h8000}, ACT_LINEAR, 1'b0);
		add_entry(5, {16'h1000, 16'h1000, 16'h1000, 16'h1000}, ACT_LINEAR, 1'b1);
		add_entry(6, {16'h7fff, 16'h8000, 16'h7fff, 16'h8000}, ACT_LEAKY_RELU, 1'b1);
		for (int e = NUM_FIXED; e < NUM_TESTS; e++) begin
			for (int i = 0; i < NUM_INPUTS; i++) begin
				r = $random(seed);
				v = r[DATA_WIDTH-1:0];
				if (e % 2 == 1) begin
					v = {{3{v[DATA_WIDTH-1]}}, v[DATA_WIDTH-1:3]}; // keep odd entries in range
				end
				xv[i*DATA_WIDTH +: DATA_WIDTH] = v;
			end
			r = $random(seed);
			add_entry(e, xv, act_op_t'(r[0]), r[1]);
		end
	endtask

	task automatic run_entry(input int e);
		logic [DATA_WIDTH-1:0] x_last;
		int                    latency;
		int                    errs_before;
		errs_before = errors;
		x_last = tab_x[e][(NUM_INPUTS-1)*DATA_WIDTH +: DATA_WIDTH];

		for (int i = 0; i < NUM_INPUTS; i++) begin
			@(negedge clk);
			i_in_we   = 1'b1;
			i_in_addr = IN_ADDR_WIDTH'(i);
			i_in_data = tab_x[e][i*DATA_WIDTH +: DATA_WIDTH];
		end
		@(negedge clk);
		i_in_we    = 1'b0;
		i_act_mode = tab_mode[e];
		i_valid    = 1'b1;
		@(negedge clk); // the start pulse was taken on the edge just passed
		i_valid = 1'b0;

		latency = 0;
		while (!o_valid) begin
			check_flag("o_busy", o_busy, 1'b1);
			// try to restart during the run and again while waiting for the layer,
			// and overwrite the last input early in the run, before it is read
			if (tab_poke[e] && (latency == 0 || latency == NUM_INPUTS + 1)) begin
				i_valid    = 1'b1;
				i_act_mode = act_op_t'(~tab_mode[e]);
				i_in_we    = (latency == 0);
				i_in_addr  = IN_ADDR_WIDTH'(NUM_INPUTS - 1);
				i_in_data  = ~x_last;
			end else begin
				i_valid = 1'b0;
				i_in_we = 1'b0;
			end
			@(negedge clk);
			latency++;
		end
		i_valid = 1'b0;
		i_in_we = 1'b0;

		checks++;
		if (latency != LATENCY) begin
			errors++;
			$display("o_valid came %0d cycles after the start pulse instead of %0d",
				latency, LATENCY);
		end
		check_flag("o_busy", o_busy, 1'b1);
		for (int n = 0; n < NUM_HIDDEN; n++) begin
			check_hidden(n, o_hidden[n*DATA_WIDTH +: DATA_WIDTH],
				expected_neuron(n, tab_x[e], tab_mode[e]));
		end
		if (e == SAT_HIGH_ENTRY) begin
			check_hidden(SAT_NEURON, o_hidden[SAT_NEURON*DATA_WIDTH +: DATA_WIDTH], 16'h7fff);
		end
		if (e == SAT_LOW_ENTRY) begin
			check_hidden(SAT_NEURON, o_hidden[SAT_NEURON*DATA_WIDTH +: DATA_WIDTH], 16'h8000);
		end

		// a single pulse, and the sequencer is free again
		@(negedge clk);
		check_flag("o_valid", o_valid, 1'b0);
		check_flag("o_busy", o_busy, 1'b0);

		$display("test %0d %s%s: %s", e,
			(tab_mode[e] == ACT_LEAKY_RELU) ? "leaky relu" : "linear",
			tab_poke[e] ? " with busy pokes" : "",
			(errors == errs_before) ? "ok" : "failed");
	endtask

	initial begin : main
		int errs_before;
		rst_n      = 1'b0;
		i_in_we    = 1'b0;
		i_in_addr  = '0;
		i_in_data  = '0;
		i_act_mode = ACT_LINEAR;
		i_valid    = 1'b0;
		seed       = 2153;

		$readmemh(WEIGHT_FILE, rom);
		build_table();

		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		errs_before = errors;
		check_flag("o_valid", o_valid, 1'b0);
		check_flag("o_busy", o_busy, 1'b0);
		for (int n = 0; n < NUM_HIDDEN; n++) begin
			check_hidden(n, o_hidden[n*DATA_WIDTH +: DATA_WIDTH], '0);
		end
		$display("reset state: %s", (errors == errs_before) ? "ok" : "failed");

		for (int e = 0; e < NUM_TESTS; e++) begin
			run_entry(e);
		end

		$display("%0d tests, %0d checks, %0d errors", NUM_TESTS + 1, checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== verilog/nn_top.sv ====
`timescale 1ns/1ps
module nn_top import nn_pkg::*; (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             i_in_we,
	input  logic [IN_ADDR_WIDTH-1:0]         i_in_addr,
	input  logic [DATA_WIDTH-1:0]            i_in_data,
	input  act_op_t                          i_act_mode,
	input  logic                             i_valid,
	output logic                             o_busy,
	output logic                             o_valid,
	output logic [NUM_HIDDEN*DATA_WIDTH-1:0] o_hidden
);

	logic [IN_ADDR_WIDTH-1:0]         idx;
	logic [DATA_WIDTH-1:0]            x;
	logic                             mac_en;
	logic                             last;
	act_op_t                          act_mode;
	logic [NUM_HIDDEN*DATA_WIDTH-1:0] weights;
	logic [NUM_HIDDEN*DATA_WIDTH-1:0] biases;

	input_sequencer u_seq (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_in_we    (i_in_we),
		.i_in_addr  (i_in_addr),
		.i_in_data  (i_in_data),
		.i_valid    (i_valid),
		.i_act_mode (i_act_mode),
		.i_done     (o_valid), // layer completion releases the sequencer
		.o_idx      (idx),
		.o_x        (x),
		.o_mac_en   (mac_en),
		.o_last     (last),
		.o_act_mode (act_mode),
		.o_busy     (o_busy)
	);

	weight_rom u_rom (
		.i_idx     (idx),
		.o_weights (weights),
		.o_biases  (biases)
	);

	feed_forward_hidden_layer u_layer (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_x        (x),
		.i_mac_en   (mac_en),
		.i_last     (last),
		.i_act_mode (act_mode),
		.i_weights  (weights),
		.i_biases   (biases),
		.o_hidden   (o_hidden),
		.o_valid    (o_valid)
	);

endmodule

// ==== verilog/feed_forward_hidden_layer.sv ====
`timescale 1ns/1ps
module feed_forward_hidden_layer import nn_pkg::*; (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [DATA_WIDTH-1:0]            i_x,
	input  logic                             i_mac_en,
	input  logic                             i_last,
	input  act_op_t                          i_act_mode,
	input  logic [NUM_HIDDEN*DATA_WIDTH-1:0] i_weights,
	input  logic [NUM_HIDDEN*DATA_WIDTH-1:0] i_biases,
	output logic [NUM_HIDDEN*DATA_WIDTH-1:0] o_hidden,
	output logic                             o_valid
);

	logic [DATA_WIDTH-1:0] node_data [NUM_HIDDEN];
	logic [NUM_HIDDEN-1:0] node_valid;
	logic                  all_valid; // every node reported in the previous cycle

	// all neurons share the input stream and each takes its own weight and bias slice
	for (genvar g = 0; g < NUM_HIDDEN; g++) begin : g_node
		feed_forward_node u_node (
			.clk        (clk),
			.rst_n      (rst_n),
			.i_x        (i_x),
			.i_weight   (i_weights[g*DATA_WIDTH +: DATA_WIDTH]),
			.i_bias     (i_biases[g*DATA_WIDTH +: DATA_WIDTH]),
			.i_mac_en   (i_mac_en),
			.i_last     (i_last),
			.i_act_mode (i_act_mode),
			.o_data     (node_data[g]),
			.o_valid    (node_valid[g])
		);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_hidden  <= '0;
			all_valid <= 1'b0;
			o_valid   <= 1'b0;
		end else begin
			// results stay on o_hidden until the next run replaces them
			for (int k = 0; k < NUM_HIDDEN; k++) begin
				if (node_valid[k]) begin
					o_hidden[k*DATA_WIDTH +: DATA_WIDTH] <= node_data[k];
				end
			end
			all_valid <= &node_valid;
			o_valid   <= all_valid; // one stage later, when the captured values are settled
		end
	end

endmodule

// ==== verilog/feed_forward_node.sv ====
`timescale 1ns/1ps
module feed_forward_node import nn_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [DATA_WIDTH-1:0] i_x,
	input  logic [DATA_WIDTH-1:0] i_weight,
	input  logic [DATA_WIDTH-1:0] i_bias,
	input  logic                  i_mac_en,
	input  logic                  i_last,
	input  act_op_t               i_act_mode,
	output logic [DATA_WIDTH-1:0] o_data,
	output logic                  o_valid
);

	logic signed [ACC_WIDTH-1:0]            product;
	logic signed [ACC_WIDTH-1:0]            scaled;
	logic signed [ACC_WIDTH-1:0]            acc;
	logic signed [ACC_WIDTH-1:0]            acc_next;
	logic signed [ACC_WIDTH-1:0]            bias_ext;
	logic signed [ACC_WIDTH-1:0]            sum;
	logic signed [ACC_WIDTH+DATA_WIDTH-1:0] leaky_prod;
	logic signed [ACC_WIDTH-1:0]            act;
	logic        [DATA_WIDTH-1:0]           sat;
	logic                                   running; // high between the first and last MAC

	always_comb begin
		product = $signed(i_x) * $signed(i_weight); // Q8.24 product
		scaled  = product >>> FRAC_BITS;            // back to Q4.12 scale

		// the first enabled cycle of a run starts from zero
		acc_next = (running ? acc : '0) + scaled;

		bias_ext   = $signed(i_bias);
		sum        = acc_next + bias_ext;
		leaky_prod = sum * ALPHA_Q;

		if (i_act_mode == ACT_LEAKY_RELU && sum < 0) begin
			act = ACC_WIDTH'(leaky_prod >>> FRAC_BITS);
		end else begin
			act = sum;
		end

		// clamp into the signed 16-bit range
		if (act > SAT_MAX) begin
			sat = SAT_MAX[DATA_WIDTH-1:0];
		end else if (act < SAT_MIN) begin
			sat = SAT_MIN[DATA_WIDTH-1:0];
		end else begin
			sat = act[DATA_WIDTH-1:0];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			running <= 1'b0;
			acc     <= '0;
			o_valid <= 1'b0;
		end else begin
			o_valid <= 1'b0;
			if (i_mac_en) begin
				acc     <= acc_next;
				running <= !i_last; // the next run begins with a clear accumulator
				o_valid <= i_last;
			end
		end
	end

	// the result register only loads on the last product of a run
	always_ff @(posedge clk) begin
		if (i_mac_en && i_last) begin
			o_data <= sat;
		end
	end

endmodule

// ==== verilog/weight_rom.sv ====
`timescale 1ns/1ps
module weight_rom import nn_pkg::*; (
	input  logic [IN_ADDR_WIDTH-1:0]         i_idx,
	output logic [NUM_HIDDEN*DATA_WIDTH-1:0] o_weights,
	output logic [NUM_HIDDEN*DATA_WIDTH-1:0] o_biases
);

	// row n holds the NUM_INPUTS weights of neuron n followed by its bias
	logic [DATA_WIDTH-1:0] mem [ROM_DEPTH];

	initial begin
		$readmemh(WEIGHT_FILE, mem);
	end

	// every neuron reads its own row at the same input index
	always_comb begin
		for (int n = 0; n < NUM_HIDDEN; n++) begin
			o_weights[n*DATA_WIDTH +: DATA_WIDTH] = mem[n*ROW_WORDS + int'(i_idx)];
			o_biases[n*DATA_WIDTH +: DATA_WIDTH]  = mem[n*ROW_WORDS + NUM_INPUTS];
		end
	end

endmodule

// ==== verilog/input_sequencer.sv ====
`timescale 1ns/1ps
module input_sequencer import nn_pkg::*; (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     i_in_we,
	input  logic [IN_ADDR_WIDTH-1:0] i_in_addr,
	input  logic [DATA_WIDTH-1:0]    i_in_data,
	input  logic                     i_valid,
	input  act_op_t                  i_act_mode,
	input  logic                     i_done,
	output logic [IN_ADDR_WIDTH-1:0] o_idx,
	output logic [DATA_WIDTH-1:0]    o_x,
	output logic                     o_mac_en,
	output logic                     o_last,
	output act_op_t                  o_act_mode,
	output logic                     o_busy
);

	logic [DATA_WIDTH-1:0]    in_buf [NUM_INPUTS];
	seq_state_t               state;
	logic [IN_ADDR_WIDTH-1:0] idx; // index being issued this cycle

	assign o_busy = (state != SEQ_IDLE);

	// host writes only land while the layer is idle
	always_ff @(posedge clk) begin
		if (i_in_we && state == SEQ_IDLE) begin
			in_buf[i_in_addr] <= i_in_data;
		end
	end

	// the input value is registered together with o_idx so that
	// the combinational ROM output lines up with it
	always_ff @(posedge clk) begin
		o_x <= in_buf[idx];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= SEQ_IDLE;
			idx        <= '0;
			o_idx      <= '0;
			o_mac_en   <= 1'b0;
			o_last     <= 1'b0;
			o_act_mode <= ACT_LINEAR;
		end else begin
			o_mac_en <= (state == SEQ_RUN);
			o_last   <= (state == SEQ_RUN) && (idx == LAST_IDX);
			o_idx    <= idx;

			case (state)
				SEQ_IDLE: begin
					if (i_valid) begin
						state      <= SEQ_RUN;
						idx        <= '0;
						o_act_mode <= i_act_mode; // mode stays fixed for the whole run
					end
				end
				SEQ_RUN: begin
					idx <= idx + 1'b1;
					if (idx == LAST_IDX) begin
						state <= SEQ_DONE;
					end
				end
				SEQ_DONE: begin
					// hold off new starts until the layer has presented its results
					if (i_done) begin
						state <= SEQ_IDLE;
					end
				end
				default: begin
					state <= SEQ_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== verilog/nn_pkg.sv ====
package nn_pkg;

	// data path sizes, every value on the data path is Q4.12
	localparam int DATA_WIDTH = 16;
	localparam int FRAC_BITS = 12;
	localparam int ACC_WIDTH = 32; // wide enough for a full sum of scaled products

	// layer shape
	localparam int NUM_INPUTS = 4;
	localparam int NUM_HIDDEN = 8;
	localparam int IN_ADDR_WIDTH = 2;
	localparam logic [IN_ADDR_WIDTH-1:0] LAST_IDX = IN_ADDR_WIDTH'(NUM_INPUTS - 1);

	// one ROM row per neuron: the weights and then the bias
	localparam int ROW_WORDS = NUM_INPUTS + 1;
	localparam int ROM_DEPTH = NUM_HIDDEN * ROW_WORDS;
	localparam string WEIGHT_FILE = "weights.hex";

	// leaky-ReLU slope, 0x0199 / 4096 is close to 0.1
	localparam logic signed [DATA_WIDTH-1:0] ALPHA_Q = 16'sh0199;

	// limits of the signed 16-bit result, held at accumulator width for comparison
	localparam logic signed [ACC_WIDTH-1:0] SAT_MAX = 32'sd32767;
	localparam logic signed [ACC_WIDTH-1:0] SAT_MIN = -32'sd32768;

	// input sequencer states
	typedef enum logic [1:0] {
		SEQ_IDLE = 2'd0,
		SEQ_RUN  = 2'd1,
		SEQ_DONE = 2'd2
	} seq_state_t;

	// activation opcode
	typedef enum logic {
		ACT_LINEAR     = 1'b0,
		ACT_LEAKY_RELU = 1'b1
	} act_op_t;

endpackage
